/* Bender.yml */
package:
  name: gat_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gat_compute_pkg.sv
      - hdl/gat_debug_pkg.sv
      - hdl/feat_loader.sv
      - hdl/dmvm_engine.sv
      - hdl/leaky_act.sv
      - hdl/debugger.sv
      - hdl/gat_core_top.sv
      - target: test
        files:
          - tests/gat_core_assertions.sv
          - tests/gat_core_tb.sv

/* hdl/debugger.sv */
`timescale 1ns/100ps
`include "gat_defs.svh"

module debugger (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ld_vld_i,
  input  logic                      ld_rdy_i,
  input  logic                      dmvm_vld_i,
  input  logic                      dmvm_rdy_i,
  input  logic                      act_vld_i,
  input  logic                      act_rdy_i,
  input  logic                      wr_en_i,
  input  logic                      wgt_wr_i,
  input  gat_compute_pkg::res_t     result_i,
  input  gat_compute_pkg::node_t    result_node_i,
  input  logic                      result_vld_i,
  input  gat_debug_pkg::dbg_sel_e   dbg_sel_i,
  output gat_debug_pkg::dbg_word_t  debug_o
);

  gat_debug_pkg::dbg_flags_t  flags_q;
  gat_debug_pkg::dbg_flags_t  flags_hit;
  gat_debug_pkg::dbg_word_t   count_q;
  gat_debug_pkg::dbg_word_t   capture_q;
  logic                       ld_rdy_q;
  logic                       dmvm_rdy_q;
  logic                       act_rdy_q;
  logic                       probe_hit;

  // Ready flags record a stage coming back to ready, so idle levels after reset
  // leave them clear.
  always_comb begin
    flags_hit          = '0;
    flags_hit.ld_vld   = ld_vld_i;
    flags_hit.ld_rdy   = ld_rdy_i && !ld_rdy_q;
    flags_hit.dmvm_vld = dmvm_vld_i;
    flags_hit.dmvm_rdy = dmvm_rdy_i && !dmvm_rdy_q;
    flags_hit.act_vld  = act_vld_i;
    flags_hit.act_rdy  = act_rdy_i && !act_rdy_q;
    flags_hit.feat_wr  = wr_en_i && !wgt_wr_i;
    flags_hit.wgt_wr   = wgt_wr_i;
  end

  assign probe_hit = result_vld_i &&
                     (result_node_i == gat_compute_pkg::node_t'(`GAT_PROBE_NODE));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q    <= '0;
      ld_rdy_q   <= 1'b1;
      dmvm_rdy_q <= 1'b1;
      act_rdy_q  <= 1'b1;
    end else begin
      flags_q    <= flags_q | flags_hit; // Sticky until reset.
      ld_rdy_q   <= ld_rdy_i;
      dmvm_rdy_q <= dmvm_rdy_i;
      act_rdy_q  <= act_rdy_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q   <= '0;
      capture_q <= '0;
    end else begin
      if (result_vld_i) begin
        count_q <= count_q + 1'b1;
      end
      if (probe_hit) begin
        capture_q <= gat_debug_pkg::dbg_word_t'(result_i); // Sign-extended.
      end
    end
  end

  always_comb begin
    debug_o = `GAT_DBG_ID;
    case (dbg_sel_i)
      gat_debug_pkg::DBG_FLAGS:   debug_o = gat_debug_pkg::dbg_word_t'(flags_q);
      gat_debug_pkg::DBG_COUNT:   debug_o = count_q;
      gat_debug_pkg::DBG_CAPTURE: debug_o = capture_q;
      default:                    debug_o = `GAT_DBG_ID;
    endcase
  end

endmodule

/* hdl/dmvm_engine.sv */
`timescale 1ns/100ps
`include "gat_defs.svh"

module dmvm_engine (
  input  logic                    clk,
  input  logic                    rst_n,
  input  gat_compute_pkg::feat_t  elem_i,
  input  logic                    elem_vld_i,
  input  logic                    elem_last_i,
  input  gat_compute_pkg::feat_t  wgt_i [`GAT_VEC_LEN],
  output gat_compute_pkg::acc_t   score_o,
  output logic                    score_vld_o,
  output logic                    rdy_o
);

  localparam int IDX_W = $clog2(`GAT_VEC_LEN);

  logic [IDX_W-1:0]       idx_q;
  logic                   active_q;
  gat_compute_pkg::acc_t  acc_q;
  gat_compute_pkg::acc_t  prod;
  gat_compute_pkg::acc_t  sum;

  assign prod = elem_i * wgt_i[idx_q]; // Signed 16x16 into 32 bits.

  always_comb begin
    if (idx_q == '0) begin
      sum = prod; // First element starts a fresh sum.
    end else begin
      sum = acc_q + prod;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q       <= '0;
      active_q    <= 1'b0;
      score_vld_o <= 1'b0;
    end else begin
      score_vld_o <= elem_vld_i && elem_last_i;
      if (elem_vld_i) begin
        idx_q    <= elem_last_i ? '0 : idx_q + 1'b1;
        active_q <= 1'b1;
      end else if (score_vld_o) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (elem_vld_i) begin
      acc_q <= sum;
    end
    if (elem_vld_i && elem_last_i) begin
      score_o <= sum;
    end
  end

  // Busy from the first element through the score pulse.
  assign rdy_o = !(active_q || elem_vld_i);

endmodule

/* hdl/feat_loader.sv */
`timescale 1ns/100ps
`include "gat_defs.svh"

module feat_loader (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wr_en_i,
  input  logic [`GAT_ADDR_W-1:0]      wr_addr_i,
  input  gat_compute_pkg::feat_t      wr_data_i,
  input  logic                        start_i,
  input  gat_compute_pkg::node_t      node_i,
  input  logic                        score_vld_i,
  output gat_compute_pkg::feat_t      elem_o,
  output logic                        elem_vld_o,
  output logic                        elem_last_o,
  output gat_compute_pkg::feat_t      wgt_o [`GAT_VEC_LEN],
  output gat_compute_pkg::node_t      node_o,
  output logic                        wgt_wr_o,
  output logic                        rdy_o,
  output logic                        busy_o
);

  localparam int FEAT_DEPTH = `GAT_NUM_NODES * `GAT_VEC_LEN;
  localparam int FEAT_AW    = $clog2(FEAT_DEPTH);
  localparam int IDX_W      = $clog2(`GAT_VEC_LEN);

  gat_compute_pkg::feat_t    feat_q [FEAT_DEPTH];
  gat_compute_pkg::ld_state_e state_q;
  logic [IDX_W-1:0]          idx_q;
  logic                      feat_wr;
  logic [IDX_W-1:0]          wgt_idx;

  // Address decode. Writes past the last weight are dropped.
  assign feat_wr  = wr_en_i && (wr_addr_i < `GAT_WGT_BASE);
  assign wgt_wr_o = wr_en_i && (wr_addr_i >= `GAT_WGT_BASE) &&
                    (wr_addr_i < `GAT_WGT_BASE + `GAT_VEC_LEN);
  assign wgt_idx  = IDX_W'(wr_addr_i - `GAT_WGT_BASE);

  always_ff @(posedge clk) begin
    if (feat_wr) begin
      feat_q[wr_addr_i[FEAT_AW-1:0]] <= wr_data_i;
    end
    if (wgt_wr_o) begin
      wgt_o[wgt_idx] <= wr_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= gat_compute_pkg::LD_IDLE;
      idx_q   <= '0;
      node_o  <= '0;
    end else begin
      case (state_q)
        gat_compute_pkg::LD_IDLE: begin
          if (start_i) begin
            state_q <= gat_compute_pkg::LD_STREAM;
            idx_q   <= '0;
            node_o  <= node_i; // Held until the result leaves.
          end
        end
        gat_compute_pkg::LD_STREAM: begin
          idx_q <= idx_q + 1'b1;
          if (idx_q == IDX_W'(`GAT_VEC_LEN - 1)) begin
            state_q <= gat_compute_pkg::LD_WAIT;
          end
        end
        gat_compute_pkg::LD_WAIT: begin
          if (score_vld_i) begin
            state_q <= gat_compute_pkg::LD_IDLE;
          end
        end
        default: state_q <= gat_compute_pkg::LD_IDLE;
      endcase
    end
  end

  // Read straight from the register file, so late writes reach unread elements.
  assign elem_o      = feat_q[{node_o, idx_q}];
  assign elem_vld_o  = (state_q == gat_compute_pkg::LD_STREAM);
  assign elem_last_o = elem_vld_o && (idx_q == IDX_W'(`GAT_VEC_LEN - 1));

  assign rdy_o  = (state_q == gat_compute_pkg::LD_IDLE);
  assign busy_o = (state_q != gat_compute_pkg::LD_IDLE);

endmodule

/* hdl/gat_compute_pkg.sv */
`include "gat_defs.svh"

package gat_compute_pkg;

  // One feature or weight word.
  typedef logic signed [`GAT_FEAT_W-1:0] feat_t;

  // Accumulator and raw score.
  typedef logic signed [`GAT_ACC_W-1:0] acc_t;

  typedef logic [$clog2(`GAT_NUM_NODES)-1:0] node_t;

  // Saturated activation output.
  typedef logic signed [15:0] res_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_STREAM, // Elements go out one per cycle.
    LD_WAIT    // Hold the node until the score is back.
  } ld_state_e;

endpackage

/* hdl/gat_core_top.sv */
`timescale 1ns/100ps
`include "gat_defs.svh"

module gat_core_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_en_i,
  input  logic [`GAT_ADDR_W-1:0]    wr_addr_i,
  input  gat_compute_pkg::feat_t    wr_data_i,
  input  logic                      start_i,
  input  gat_compute_pkg::node_t    node_i,
  input  gat_debug_pkg::dbg_sel_e   dbg_sel_i,
  output gat_compute_pkg::res_t     result_o,
  output gat_compute_pkg::node_t    result_node_o,
  output logic                      result_vld_o,
  output logic                      busy_o,
  output gat_debug_pkg::dbg_word_t  debug_o
);

  gat_compute_pkg::feat_t  elem;
  logic                    elem_vld;
  logic                    elem_last;
  gat_compute_pkg::feat_t  wgt [`GAT_VEC_LEN];
  gat_compute_pkg::node_t  node;
  logic                    wgt_wr;
  logic                    ld_rdy;
  gat_compute_pkg::acc_t   score;
  logic                    score_vld;
  logic                    dmvm_rdy;
  logic                    act_rdy;

  feat_loader feat_loader_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .start_i     (start_i),
    .node_i      (node_i),
    .score_vld_i (score_vld),
    .elem_o      (elem),
    .elem_vld_o  (elem_vld),
    .elem_last_o (elem_last),
    .wgt_o       (wgt),
    .node_o      (node),
    .wgt_wr_o    (wgt_wr),
    .rdy_o       (ld_rdy),
    .busy_o      (busy_o)
  );

  dmvm_engine dmvm_engine_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .elem_i      (elem),
    .elem_vld_i  (elem_vld),
    .elem_last_i (elem_last),
    .wgt_i       (wgt),
    .score_o     (score),
    .score_vld_o (score_vld),
    .rdy_o       (dmvm_rdy)
  );

  leaky_act leaky_act_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .score_i       (score),
    .score_vld_i   (score_vld),
    .node_i        (node), // Loader holds the node until the score is back.
    .result_o      (result_o),
    .result_node_o (result_node_o),
    .result_vld_o  (result_vld_o),
    .rdy_o         (act_rdy)
  );

  debugger debugger_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_vld_i      (elem_vld),
    .ld_rdy_i      (ld_rdy),
    .dmvm_vld_i    (score_vld),
    .dmvm_rdy_i    (dmvm_rdy),
    .act_vld_i     (result_vld_o),
    .act_rdy_i     (act_rdy),
    .wr_en_i       (wr_en_i),
    .wgt_wr_i      (wgt_wr),
    .result_i      (result_o),
    .result_node_i (result_node_o),
    .result_vld_i  (result_vld_o),
    .dbg_sel_i     (dbg_sel_i),
    .debug_o       (debug_o)
  );

endmodule

/* hdl/gat_debug_pkg.sv */
package gat_debug_pkg;

  typedef logic [31:0] dbg_word_t;

  // Sticky stage flags, msb first.
  typedef struct packed {
    logic ld_vld;
    logic ld_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic act_vld;
    logic act_rdy;
    logic feat_wr;
    logic wgt_wr;
  } dbg_flags_t;

  // Debug word select.
  typedef enum logic [1:0] {
    DBG_FLAGS,
    DBG_COUNT,
    DBG_CAPTURE,
    DBG_ID
  } dbg_sel_e;

endpackage

/* hdl/gat_defs.svh */
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// Datapath widths.
`define GAT_FEAT_W      16
`define GAT_ACC_W       32

// Graph sizes.
`define GAT_VEC_LEN     4
`define GAT_NUM_NODES   4

// Write port map. Features sit node-major below the weight base.
`define GAT_ADDR_W      5
`define GAT_WGT_BASE    16

// Debug constants.
`define GAT_PROBE_NODE  2
`define GAT_DBG_ID      32'h4741_5401

`endif

/* hdl/leaky_act.sv */
`timescale 1ns/100ps

module leaky_act (
  input  logic                    clk,
  input  logic                    rst_n,
  input  gat_compute_pkg::acc_t   score_i,
  input  logic                    score_vld_i,
  input  gat_compute_pkg::node_t  node_i,
  output gat_compute_pkg::res_t   result_o,
  output gat_compute_pkg::node_t  result_node_o,
  output logic                    result_vld_o,
  output logic                    rdy_o
);

  localparam int RES_W = $bits(gat_compute_pkg::res_t);
  localparam gat_compute_pkg::acc_t SAT_MAX = (2 ** (RES_W - 1)) - 1;
  localparam gat_compute_pkg::acc_t SAT_MIN = -(2 ** (RES_W - 1));

  gat_compute_pkg::acc_t  act;
  gat_compute_pkg::res_t  sat;

  // Negative slope of 1/8.
  assign act = (score_i < 0) ? (score_i >>> 3) : score_i;

  always_comb begin
    if (act > SAT_MAX) begin
      sat = SAT_MAX[RES_W-1:0];
    end else if (act < SAT_MIN) begin
      sat = SAT_MIN[RES_W-1:0];
    end else begin
      sat = act[RES_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_vld_o <= 1'b0;
    end else begin
      result_vld_o <= score_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (score_vld_i) begin
      result_o      <= sat;
      result_node_o <= node_i;
    end
  end

  assign rdy_o = !result_vld_o; // Only busy while the pulse is out.

endmodule

/* sim.f */
+incdir+hdl
hdl/gat_compute_pkg.sv
hdl/gat_debug_pkg.sv
hdl/feat_loader.sv
hdl/dmvm_engine.sv
hdl/leaky_act.sv
hdl/debugger.sv
hdl/gat_core_top.sv
tests/gat_core_assertions.sv
tests/gat_core_tb.sv

/* tests/gat_core_assertions.sv */
`timescale 1ns/100ps

module gat_core_assertions (
  input logic clk,
  input logic rst_n,
  input logic start_i,
  input logic busy_i,
  input logic result_vld_i
);

  int fail_count = 0;

  // Results leave as single-cycle pulses.
  single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    result_vld_i |=> !result_vld_i)
    else begin
      $error("result_vld_o high on two consecutive cycles");
      fail_count++;
    end

  fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    start_i && !busy_i |-> ##6 result_vld_i)
    else begin
      $error("no result 6 cycles after an accepted start");
      fail_count++;
    end

  // Loader is back to idle once the result is out.
  idle_after_result: assert property (@(posedge clk) disable iff (!rst_n)
    result_vld_i && !start_i |=> !busy_i)
    else begin
      $error("busy_o still high after result_vld_o without a new start");
      fail_count++;
    end

endmodule

bind gat_core_top gat_core_assertions gat_core_assertions_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .start_i      (start_i),
  .busy_i       (busy_o),
  .result_vld_i (result_vld_o)
);

/* tests/gat_core_tb.sv */
`timescale 1ns/100ps
`include "gat_defs.svh"

module gat_core_tb;

  localparam int TIMEOUT = 50;

  typedef logic [`GAT_ADDR_W-1:0] addr_t;
  typedef enum {OP_WR, OP_RUN, OP_BUSY, OP_DBG} op_e;

  typedef struct {
    op_e                       op;
    addr_t                     addr;     // Write address, or node for runs.
    gat_compute_pkg::feat_t    data;     // Write data, or the node poked while busy.
    bit                        rnd;
    gat_debug_pkg::dbg_sel_e   sel;
    gat_debug_pkg::dbg_word_t  exp_word;
  } step_t;

  logic                      clk;
  logic                      rst_n;
  logic                      wr_en_i;
  addr_t                     wr_addr_i;
  gat_compute_pkg::feat_t    wr_data_i;
  logic                      start_i;
  gat_compute_pkg::node_t    node_i;
  gat_debug_pkg::dbg_sel_e   dbg_sel_i;
  gat_compute_pkg::res_t     result_o;
  gat_compute_pkg::node_t    result_node_o;
  logic                      result_vld_o;
  logic                      busy_o;
  gat_debug_pkg::dbg_word_t  debug_o;

  step_t                     steps [$];
  gat_compute_pkg::feat_t    feat_m [`GAT_NUM_NODES * `GAT_VEC_LEN];
  gat_compute_pkg::feat_t    wgt_m [`GAT_VEC_LEN];
  gat_debug_pkg::dbg_word_t  cap_m = '0;
  integer                    seed = 32'hc9af;

  gat_core_top gat_core_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // Bound checker failures end the run at once.
  always @(negedge clk) begin
    if (gat_core_top_inst.gat_core_assertions_inst.fail_count != 0) begin
      stop_run("a bound assertion on the core failed");
    end
  end

  task automatic check_result(input string name, input gat_compute_pkg::res_t exp_v,
                              input gat_compute_pkg::res_t act_v);
    if (act_v !== exp_v)
      stop_run($sformatf("mismatch %s: expected %0d actual %0d", name, exp_v, act_v));
  endtask

  task automatic check_node(input string name, input gat_compute_pkg::node_t exp_v,
                            input gat_compute_pkg::node_t act_v);
    if (act_v !== exp_v)
      stop_run($sformatf("mismatch %s: expected %0d actual %0d", name, exp_v, act_v));
  endtask

  task automatic check_debug(input string name, input gat_debug_pkg::dbg_word_t exp_v,
                             input gat_debug_pkg::dbg_word_t act_v);
    if (act_v !== exp_v)
      stop_run($sformatf("mismatch %s: expected %08h actual %08h", name, exp_v, act_v));
  endtask

  // Dot product, slope of 1/8 below zero, then clamp to 16 bits.
  function automatic gat_compute_pkg::res_t model_result(input gat_compute_pkg::node_t n);
    gat_compute_pkg::acc_t sum;
    sum = 0;
    for (int k = 0; k < `GAT_VEC_LEN; k++) begin
      sum = sum + feat_m[n * `GAT_VEC_LEN + k] * wgt_m[k];
    end
    if (sum < 0) begin
      sum = sum >>> 3;
    end
    if (sum > 32767) return 16'sh7fff;
    else if (sum < -32768) return 16'sh8000;
    else return gat_compute_pkg::res_t'(sum);
  endfunction

  task automatic add_wr(input int a, input int d, input bit rnd);
    steps.push_back('{OP_WR, addr_t'(a), gat_compute_pkg::feat_t'(d), rnd,
                      gat_debug_pkg::DBG_FLAGS, 32'h0});
  endtask

  task automatic add_run(input op_e op, input int n, input int other);
    steps.push_back('{op, addr_t'(n), gat_compute_pkg::feat_t'(other), 1'b0,
                      gat_debug_pkg::DBG_FLAGS, 32'h0});
  endtask

  task automatic add_dbg(input gat_debug_pkg::dbg_sel_e sel,
                         input gat_debug_pkg::dbg_word_t w);
    steps.push_back('{OP_DBG, addr_t'(0), gat_compute_pkg::feat_t'(0), 1'b0, sel, w});
  endtask

  task automatic write_reg(input addr_t a, input gat_compute_pkg::feat_t d);
    @(negedge clk);
    wr_en_i   = 1'b1;
    wr_addr_i = a;
    wr_data_i = d;
    @(negedge clk);
    wr_en_i = 1'b0;
    if (a < `GAT_WGT_BASE) feat_m[a] = d;
    else if (a < `GAT_WGT_BASE + `GAT_VEC_LEN) wgt_m[a - `GAT_WGT_BASE] = d;
  endtask

  task automatic run_node(input gat_compute_pkg::node_t n, input bit poke,
                          input gat_compute_pkg::node_t other);
    gat_compute_pkg::res_t exp_res;
    int cycles;
    exp_res = model_result(n);
    cycles  = 0;
    while (busy_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy_o) stop_run("timeout waiting for busy_o to fall before a start");
    @(negedge clk);
    start_i = 1'b1;
    node_i  = n;
    @(negedge clk);
    start_i = 1'b0;
    cycles  = 1;
    if (poke) begin
      if (!busy_o) stop_run("busy_o is low right after an accepted start");
      start_i = 1'b1; // Ignored by the loader.
      node_i  = other;
      @(negedge clk);
      start_i = 1'b0;
      cycles  = 2;
    end
    while (!result_vld_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!result_vld_o) stop_run("timeout waiting for result_vld_o");
    check_result($sformatf("result of node %0d", n), exp_res, result_o);
    check_node($sformatf("result_node_o of node %0d", n), n, result_node_o);
    if (cycles != 6)
      stop_run($sformatf("mismatch latency of node %0d: expected 6 actual %0d", n, cycles));
    if (n == `GAT_PROBE_NODE) cap_m = {{16{exp_res[15]}}, exp_res};
    if (poke) begin
      repeat (8) begin
        @(negedge clk);
        if (result_vld_o) stop_run("a start pulsed while busy produced an extra result");
      end
    end
  endtask

  task automatic read_debug(input gat_debug_pkg::dbg_sel_e sel,
                            input gat_debug_pkg::dbg_word_t w);
    @(negedge clk);
    dbg_sel_i = sel;
    @(negedge clk);
    check_debug($sformatf("debug %s", sel.name()), w, debug_o);
  endtask

  initial begin
    step_t s;
    rst_n = 1'b0;
    wr_en_i = 1'b0;
    wr_addr_i = '0;
    wr_data_i = '0;
    start_i = 1'b0;
    node_i = '0;
    dbg_sel_i = gat_debug_pkg::DBG_FLAGS;
    foreach (feat_m[k]) feat_m[k] = '0;
    foreach (wgt_m[k]) wgt_m[k] = '0;

    add_dbg(gat_debug_pkg::DBG_FLAGS, 32'h0);
    add_dbg(gat_debug_pkg::DBG_COUNT, 32'h0);
    add_dbg(gat_debug_pkg::DBG_CAPTURE, 32'h0);
    add_dbg(gat_debug_pkg::DBG_ID, `GAT_DBG_ID);
    add_wr(16, 3, 0);
    add_wr(17, -2, 0);
    add_wr(18, 5, 0);
    add_wr(19, 1, 0);
    for (int k = 0; k < 16; k++) add_wr(k, k * 9 - 60, (k == 5 || k == 14));
    for (int n = 0; n < 4; n++) add_run(OP_RUN, n, 0);
    add_run(OP_BUSY, 1, 3);
    add_dbg(gat_debug_pkg::DBG_COUNT, 32'd5);
    add_dbg(gat_debug_pkg::DBG_CAPTURE, 32'h0);
    add_wr(20, 16'h7fff, 0); // Lies past the weights and is dropped.
    add_wr(25, -1, 0);
    add_wr(31, 1234, 0);
    add_run(OP_RUN, 2, 0);
    add_run(OP_RUN, 1, 0);
    add_dbg(gat_debug_pkg::DBG_CAPTURE, 32'h0);
    for (int k = 0; k < 4; k++) begin
      add_wr(16 + k, 20000, 0);
      add_wr(12 + k, 20000, 0); // Node 3 clamps high.
      add_wr(4 + k, -20000, 0); // Node 1 clamps low.
      add_wr(8 + k, (k == 0) ? 1 : (k == 1) ? -2 : 0, 0);
    end
    for (int n = 3; n > 0; n--) add_run(OP_RUN, n, 0);
    add_dbg(gat_debug_pkg::DBG_CAPTURE, 32'h0);
    add_dbg(gat_debug_pkg::DBG_FLAGS, 32'h0000_00ff);
    add_dbg(gat_debug_pkg::DBG_COUNT, 32'd10);
    add_dbg(gat_debug_pkg::DBG_ID, `GAT_DBG_ID);

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    if (busy_o !== 1'b0 || result_vld_o !== 1'b0)
      stop_run("busy_o or result_vld_o high after reset");

    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        OP_WR:   write_reg(s.addr, s.rnd ? gat_compute_pkg::feat_t'($random(seed)) : s.data);
        OP_RUN:  run_node(gat_compute_pkg::node_t'(s.addr), 1'b0, '0);
        OP_BUSY: run_node(gat_compute_pkg::node_t'(s.addr), 1'b1,
                          gat_compute_pkg::node_t'(s.data));
        default: read_debug(s.sel, (s.sel == gat_debug_pkg::DBG_CAPTURE) ? cap_m : s.exp_word);
      endcase
    end
    if (gat_core_top_inst.gat_core_assertions_inst.fail_count != 0) begin
      stop_run("a bound assertion on the core failed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
